// File: led_panel_top.f
+incdir+logic
logic/led_panel_pkg.sv
logic/pixel_router.sv
logic/block_buffer.sv
logic/driver_serializer.sv
logic/led_panel_top.sv
verification/led_panel_assert.sv
verification/led_panel_tb.sv

// File: verification/led_panel_tb.sv
`timescale 1ns/1ns
`include "led_panel_defs.svh"

module led_panel_tb;
    import led_panel_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int BITS_PER_PLANE = `LED_NUM_CHANNELS * `LED_BLOCK_PIXELS;
    localparam int FRAME_CYCLES = 1 + `LED_COLOR_BITS * (2 * BITS_PER_PLANE + 1);
    localparam int NUM_FRAMES   = 8;
    localparam int MID_WRITES   = 12;
    // Full write, sof, mid-frame gap and settle time around each frame
    localparam int EXTRA_CYCLES = `LED_PANEL_W * `LED_PANEL_H + 50;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (FRAME_CYCLES + EXTRA_CYCLES) + 200;

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       pix_valid;
    coord_x_t                   pix_x;
    coord_y_t                   pix_y;
    pixel_t                     pix_data;
    logic                       sof;
    logic                       drv_sclk;
    logic                       drv_lat;
    logic [`LED_NUM_BLOCKS-1:0] drv_sin;
    plane_t                     plane;
    logic                       frame_done;

    // Model of the two banks of every block
    pixel_t back_mem  [`LED_NUM_BLOCKS][`LED_BLOCK_PIXELS];
    pixel_t front_mem [`LED_NUM_BLOCKS][`LED_BLOCK_PIXELS];

    logic [31:0] rand_state = 32'd54;
    int errors       = 0;
    int bits_checked = 0;
    int frames_run   = 0;
    int assert_fails = 0;
    int bit_cnt;
    int lat_cnt;
    int done_cnt;
    int frame_cyc;
    int exp_plane;
    logic                       sof_q = 1'b0;
    logic [`LED_NUM_BLOCKS-1:0] sin_q;

    always #(CLK_PERIOD / 2) clk = ~clk;

    led_panel_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .pix_valid  (pix_valid),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_data   (pix_data),
        .sof        (sof),
        .drv_sclk   (drv_sclk),
        .drv_lat    (drv_lat),
        .drv_sin    (drv_sin),
        .plane      (plane),
        .frame_done (frame_done)
    );

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Red nibble goes out first, blue last
    function automatic logic expected_bit(pixel_t px, int ch, int p);
        logic [`LED_COLOR_BITS-1:0] nib;
        case (ch)
            0:       nib = px[11:8];
            1:       nib = px[7:4];
            default: nib = px[3:0];
        endcase
        return nib[p];
    endfunction

    task automatic write_pixel(input int x, input int y, input pixel_t data);
        int bx;
        int by;
        int blk;
        int pix;
        bx  = x / `LED_BLOCK_W;
        by  = y / `LED_BLOCK_H;
        blk = by * `LED_BLOCK_COLS + bx;
        pix = (y - by * `LED_BLOCK_H) * `LED_BLOCK_W + (x - bx * `LED_BLOCK_W);
        @(negedge clk);
        pix_valid = 1'b1;
        pix_x     = coord_x_t'(x);
        pix_y     = coord_y_t'(y);
        pix_data  = data;
        back_mem[blk][pix] = data;
    endtask

    task automatic end_writes();
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic write_full_frame();
        for (int y = 0; y < `LED_PANEL_H; y++) begin
            for (int x = 0; x < `LED_PANEL_W; x++) begin
                write_pixel(x, y, pixel_t'(lcg_next() >> 12));
            end
        end
        end_writes();
    endtask

    task automatic write_random_pixels(input int count);
        int x;
        int y;
        for (int i = 0; i < count; i++) begin
            x = int'(lcg_next() >> 16) % `LED_PANEL_W;
            y = int'(lcg_next() >> 16) % `LED_PANEL_H;
            write_pixel(x, y, pixel_t'(lcg_next() >> 12));
        end
        end_writes();
    endtask

    // Corners and the pixels on both sides of the block boundaries
    task automatic write_edge_pixels();
        write_pixel(0, 0, pixel_t'(lcg_next() >> 12));
        write_pixel(`LED_PANEL_W - 1, 0, pixel_t'(lcg_next() >> 12));
        write_pixel(0, `LED_PANEL_H - 1, pixel_t'(lcg_next() >> 12));
        write_pixel(`LED_PANEL_W - 1, `LED_PANEL_H - 1, pixel_t'(lcg_next() >> 12));
        write_pixel(`LED_BLOCK_W - 1, `LED_BLOCK_H - 1, pixel_t'(lcg_next() >> 12));
        write_pixel(`LED_BLOCK_W, `LED_BLOCK_H, pixel_t'(lcg_next() >> 12));
        end_writes();
        write_random_pixels(6);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (drv_sclk !== 1'b0) begin
                errors++;
                $display("FAIL t=%0t drv_sclk expected 0 got %0b", $time, drv_sclk);
            end
            if (drv_lat !== 1'b0) begin
                errors++;
                $display("FAIL t=%0t drv_lat expected 0 got %0b", $time, drv_lat);
            end
            if (frame_done !== 1'b0) begin
                errors++;
                $display("FAIL t=%0t frame_done expected 0 got %0b", $time, frame_done);
            end
            if (plane !== '0) begin
                errors++;
                $display("FAIL t=%0t plane expected 0 got %0d", $time, plane);
            end
        end
    endtask

    task automatic run_frame(input int mid_writes, input bit mid_sof);
        pixel_t swap_tmp [`LED_NUM_BLOCKS][`LED_BLOCK_PIXELS];
        int     wait_cyc;
        // Banks exchange roles at the swap
        swap_tmp  = front_mem;
        front_mem = back_mem;
        back_mem  = swap_tmp;
        lat_cnt   = 0;
        done_cnt  = 0;
        @(negedge clk);
        sof = 1'b1;
        @(negedge clk);
        sof = 1'b0;
        repeat (20) @(negedge clk);
        if (mid_writes > 0) begin
            write_random_pixels(mid_writes);
        end
        // Busy serializer must ignore this one
        if (mid_sof) begin
            @(negedge clk);
            sof = 1'b1;
            @(negedge clk);
            sof = 1'b0;
        end
        wait_cyc = 0;
        while (done_cnt == 0 && wait_cyc < 2 * FRAME_CYCLES) begin
            @(posedge clk);
            wait_cyc++;
        end
        if (done_cnt == 0) begin
            errors++;
            $display("Frame %0d never raised frame_done", frames_run);
        end
        repeat (4) @(negedge clk);
        if (lat_cnt != `LED_COLOR_BITS) begin
            errors++;
            $display("FAIL t=%0t drv_lat pulses expected %0d got %0d",
                     $time, `LED_COLOR_BITS, lat_cnt);
        end
        if (done_cnt != 1) begin
            errors++;
            $display("FAIL t=%0t frame_done pulses expected 1 got %0d", $time, done_cnt);
        end
        frames_run++;
    endtask

    // sof as the serializer saw it at the last rising edge
    always @(posedge clk) begin
        sof_q <= sof;
    end

    // Samples mid-cycle, while drv_sclk is high
    always @(negedge clk) begin : monitor
        int   pix;
        int   ch;
        logic exp;
        logic exp_done;
        if (arst_n) begin
            // A frame starts only from idle, the cycle after sof
            if (frame_cyc > 0 && frame_cyc < FRAME_CYCLES) begin
                frame_cyc++;
            end else if (frame_cyc == 0 && sof_q) begin
                frame_cyc = 1;
                bit_cnt   = 0;
                exp_plane = `LED_COLOR_BITS - 1;
            end else begin
                frame_cyc = 0;
            end
            if (drv_sclk) begin
                if (bit_cnt < BITS_PER_PLANE && exp_plane >= 0) begin
                    pix = bit_cnt / `LED_NUM_CHANNELS;
                    ch  = bit_cnt % `LED_NUM_CHANNELS;
                    for (int b = 0; b < `LED_NUM_BLOCKS; b++) begin
                        exp = expected_bit(front_mem[b][pix], ch, exp_plane);
                        bits_checked++;
                        if (sin_q[b] !== exp) begin
                            errors++;
                            $display("FAIL t=%0t drv_sin[%0d] low half expected %0b got %0b",
                                     $time, b, exp, sin_q[b]);
                        end
                        if (drv_sin[b] !== exp) begin
                            errors++;
                            $display("FAIL t=%0t drv_sin[%0d] expected %0b got %0b",
                                     $time, b, exp, drv_sin[b]);
                        end
                    end
                end else begin
                    errors++;
                    $display("Shift clock pulse outside a bit plane at t=%0t", $time);
                end
                bit_cnt++;
            end
            if (drv_lat) begin
                if (bit_cnt != BITS_PER_PLANE) begin
                    errors++;
                    $display("FAIL t=%0t drv_sclk edges expected %0d got %0d",
                             $time, BITS_PER_PLANE, bit_cnt);
                end
                if (plane !== plane_t'(exp_plane)) begin
                    errors++;
                    $display("FAIL t=%0t plane expected %0d got %0d", $time, exp_plane, plane);
                end
                lat_cnt++;
                bit_cnt = 0;
                exp_plane--;
            end
            // Last latch of the frame, 197 cycles after sof
            exp_done = (frame_cyc == FRAME_CYCLES);
            if (frame_done !== exp_done) begin
                errors++;
                $display("FAIL t=%0t frame_done expected %0b got %0b",
                         $time, exp_done, frame_done);
            end
            if (frame_done) begin
                done_cnt++;
            end
        end
        sin_q = drv_sin;
    end

    initial begin
        arst_n    = 1'b0;
        pix_valid = 1'b0;
        pix_x     = '0;
        pix_y     = '0;
        pix_data  = '0;
        sof       = 1'b0;
        bit_cnt   = 0;
        lat_cnt   = 0;
        done_cnt  = 0;
        frame_cyc = 0;
        exp_plane = `LED_COLOR_BITS - 1;
        for (int b = 0; b < `LED_NUM_BLOCKS; b++) begin
            for (int p = 0; p < `LED_BLOCK_PIXELS; p++) begin
                back_mem[b][p]  = '0;
                front_mem[b][p] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_idle(20);

        // Cleared buffers first, then the banks alternate
        run_frame(0, 1'b0);
        write_full_frame();
        run_frame(MID_WRITES, 1'b0);
        run_frame(MID_WRITES, 1'b1);
        write_edge_pixels();
        run_frame(0, 1'b0);
        for (int f = 4; f < NUM_FRAMES; f++) begin
            write_full_frame();
            run_frame((f % 2 == 1) ? MID_WRITES : 0, (f % 3 == 0));
        end

        assert_fails = dut_i.ser_i.assert_i.fail_cnt;
        $display("Frames: %0d, bits checked: %0d, errors: %0d, assertion failures: %0d",
                 frames_run, bits_checked, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verification/led_panel_assert.sv
`timescale 1ns/1ns

module led_panel_assert (
    input logic clk,
    input logic arst_n,
    input logic swap,
    input logic drv_sclk,
    input logic drv_lat,
    input logic frame_done
);
    int fail_cnt = 0;

    // Latch only while the shift clock is low
    lat_sclk_apart: assert property (@(posedge clk) disable iff (!arst_n)
        !(drv_lat && drv_sclk))
        else begin
            fail_cnt++;
            $error("drv_lat and drv_sclk high together");
        end

    swap_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        swap |=> !swap)
        else begin
            fail_cnt++;
            $error("swap held longer than one cycle");
        end

    // End of frame coincides with the last latch
    done_with_lat: assert property (@(posedge clk) disable iff (!arst_n)
        frame_done |-> drv_lat)
        else begin
            fail_cnt++;
            $error("frame_done without drv_lat");
        end

endmodule

bind driver_serializer led_panel_assert assert_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .swap       (swap),
    .drv_sclk   (drv_sclk),
    .drv_lat    (drv_lat),
    .frame_done (frame_done)
);

// File: logic/led_panel_top.sv
`timescale 1ns/1ns
`include "led_panel_defs.svh"

module led_panel_top (
    input  logic                        clk,
    input  logic                        arst_n,

    // Pixel input
    input  logic                        pix_valid,
    input  led_panel_pkg::coord_x_t     pix_x,
    input  led_panel_pkg::coord_y_t     pix_y,
    input  led_panel_pkg::pixel_t       pix_data,

    // Frame timing
    input  logic                        sof,

    // Drivers
    output logic                        drv_sclk,
    output logic                        drv_lat,
    output logic [`LED_NUM_BLOCKS-1:0]  drv_sin,
    output led_panel_pkg::plane_t       plane,
    output logic                        frame_done
);
    import led_panel_pkg::*;

    // Router to buffers
    pixel_wr_t                  wr;
    logic [`LED_NUM_BLOCKS-1:0] wr_en;

    // Serializer to buffers
    logic       swap;
    pixel_idx_t rd_pixel;
    pixel_t     blk_data [`LED_NUM_BLOCKS];

    pixel_router router_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_data  (pix_data),
        .wr        (wr),
        .wr_en     (wr_en)
    );

    // One frame memory per driver line
    for (genvar i = 0; i < `LED_NUM_BLOCKS; i++) begin : gen_blk
        block_buffer buf_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .wr       (wr),
            .wr_en    (wr_en[i]),
            .swap     (swap),
            .rd_pixel (rd_pixel),
            .rd_data  (blk_data[i])
        );
    end

    driver_serializer ser_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .sof        (sof),
        .blk_data   (blk_data),
        .swap       (swap),
        .rd_pixel   (rd_pixel),
        .drv_sclk   (drv_sclk),
        .drv_lat    (drv_lat),
        .drv_sin    (drv_sin),
        .plane      (plane),
        .frame_done (frame_done)
    );

endmodule

// File: logic/driver_serializer.sv
`timescale 1ns/1ns
`include "led_panel_defs.svh"

module driver_serializer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        sof,
    input  led_panel_pkg::pixel_t       blk_data [`LED_NUM_BLOCKS],
    output logic                        swap,
    output led_panel_pkg::pixel_idx_t   rd_pixel,
    output logic                        drv_sclk,
    output logic                        drv_lat,
    output logic [`LED_NUM_BLOCKS-1:0]  drv_sin,
    output led_panel_pkg::plane_t       plane,
    output logic                        frame_done
);
    import led_panel_pkg::*;

    localparam int LAST_CHAN = `LED_NUM_CHANNELS - 1;

    // Bit position inside a 12-bit pixel word
    typedef logic [$clog2(`LED_PIXEL_BITS)-1:0] bit_idx_t;

    ser_state_t state;
    ser_state_t state_nxt;
    logic [1:0] chan;
    bit_idx_t   bit_sel;
    logic       last_bit;
    logic       last_plane;

    // Last channel of the last pixel in the plane
    assign last_bit = (rd_pixel == pixel_idx_t'(`LED_BLOCK_PIXELS - 1))
                      && (chan == 2'(LAST_CHAN));

    assign last_plane = (plane == '0);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (sof) state_nxt = SWAP;
            SWAP:       state_nxt = SHIFT_LOW;
            SHIFT_LOW:  state_nxt = SHIFT_HIGH;
            SHIFT_HIGH: state_nxt = last_bit ? LATCH : SHIFT_LOW;
            LATCH:      state_nxt = last_plane ? IDLE : SHIFT_LOW;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Pixel, channel and plane counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pixel <= '0;
            chan     <= '0;
            plane    <= '0;
        end else begin
            case (state)
                SWAP: begin
                    rd_pixel <= '0;
                    chan     <= '0;
                    plane    <= plane_t'(`LED_COLOR_BITS - 1);
                end
                // Advance after the rising shift clock
                SHIFT_HIGH: begin
                    if (!last_bit) begin
                        if (chan == 2'(LAST_CHAN)) begin
                            chan     <= '0;
                            rd_pixel <= rd_pixel + 1'b1;
                        end else begin
                            chan <= chan + 1'b1;
                        end
                    end
                end
                LATCH: begin
                    rd_pixel <= '0;
                    chan     <= '0;
                    if (!last_plane) begin
                        plane <= plane - 1'b1;
                    end
                end
                default: begin
                    rd_pixel <= rd_pixel;
                end
            endcase
        end
    end

    // Channel 0 is red in the top nibble
    always_comb begin
        bit_sel = bit_idx_t'((LAST_CHAN - chan) * `LED_COLOR_BITS + plane);
        for (int b = 0; b < `LED_NUM_BLOCKS; b++) begin
            drv_sin[b] = blk_data[b][bit_sel];
        end
    end

    // Data is stable across both halves of a bit
    assign swap       = (state == SWAP);
    assign drv_sclk   = (state == SHIFT_HIGH);
    assign drv_lat    = (state == LATCH);
    assign frame_done = drv_lat && last_plane;

endmodule

// File: logic/block_buffer.sv
`timescale 1ns/1ns
`include "led_panel_defs.svh"

module block_buffer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  led_panel_pkg::pixel_wr_t    wr,
    input  logic                        wr_en,
    input  logic                        swap,
    input  led_panel_pkg::pixel_idx_t   rd_pixel,
    output led_panel_pkg::pixel_t       rd_data
);
    import led_panel_pkg::*;

    localparam int NUM_BANKS = 2;

    // Two banks, one shown while the other is filled
    pixel_t mem [NUM_BANKS][`LED_BLOCK_PIXELS];

    logic front_sel;
    logic back_sel;

    assign back_sel = ~front_sel;

    // Bank select flips once per frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= back_sel;
        end
    end

    // Incoming pixels only touch the back bank
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int p = 0; p < `LED_BLOCK_PIXELS; p++) begin
                    mem[b][p] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[back_sel][wr.pix] <= wr.data;
        end
    end

    // Front bank read is combinational
    assign rd_data = mem[front_sel][rd_pixel];

endmodule

// File: logic/pixel_router.sv
`timescale 1ns/1ns
`include "led_panel_defs.svh"

module pixel_router (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pix_valid,
    input  led_panel_pkg::coord_x_t     pix_x,
    input  led_panel_pkg::coord_y_t     pix_y,
    input  led_panel_pkg::pixel_t       pix_data,
    output led_panel_pkg::pixel_wr_t    wr,
    output logic [`LED_NUM_BLOCKS-1:0]  wr_en
);
    import led_panel_pkg::*;

    block_idx_t                 blk_num;
    pixel_idx_t                 pix_num;
    logic [`LED_NUM_BLOCKS-1:0] blk_onehot;

    // Block row and column from the upper coordinate part
    always_comb begin
        blk_num = block_idx_t'((pix_y / `LED_BLOCK_H) * `LED_BLOCK_COLS
                               + (pix_x / `LED_BLOCK_W));
    end

    // Row-major position inside the block
    always_comb begin
        pix_num = pixel_idx_t'((pix_y % `LED_BLOCK_H) * `LED_BLOCK_W
                               + (pix_x % `LED_BLOCK_W));
    end

    always_comb begin
        blk_onehot = '0;
        blk_onehot[blk_num] = 1'b1;
    end

    // Write enable, one cycle per strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= '0;
        end else if (pix_valid) begin
            wr_en <= blk_onehot;
        end else begin
            wr_en <= '0;
        end
    end

    // Write payload, valid while wr_en is high
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            wr <= '{blk: blk_num, pix: pix_num, data: pix_data};
        end
    end

endmodule

// File: logic/led_panel_pkg.sv
`include "led_panel_defs.svh"

package led_panel_pkg;

    // Global pixel coordinates
    typedef logic [$clog2(`LED_PANEL_W)-1:0] coord_x_t;
    typedef logic [$clog2(`LED_PANEL_H)-1:0] coord_y_t;

    // Block number and pixel number inside a block
    typedef logic [$clog2(`LED_NUM_BLOCKS)-1:0]   block_idx_t;
    typedef logic [$clog2(`LED_BLOCK_PIXELS)-1:0] pixel_idx_t;

    // Red in the top nibble, then green, then blue
    typedef logic [`LED_PIXEL_BITS-1:0] pixel_t;

    // Bit-plane index, MSB plane is shifted first
    typedef logic [$clog2(`LED_COLOR_BITS)-1:0] plane_t;

    // One routed pixel write
    typedef struct packed {
        block_idx_t blk;
        pixel_idx_t pix;
        pixel_t     data;
    } pixel_wr_t;

    // Serializer FSM
    typedef enum logic [2:0] {
        IDLE,
        SWAP,
        SHIFT_LOW,
        SHIFT_HIGH,
        LATCH
    } ser_state_t;

endpackage

// File: logic/led_panel_defs.svh
`ifndef LED_PANEL_DEFS_SVH
`define LED_PANEL_DEFS_SVH

// Panel is split into a grid of blocks, one serial driver line each
`define LED_BLOCK_COLS 2
`define LED_BLOCK_ROWS 2
`define LED_NUM_BLOCKS (`LED_BLOCK_COLS * `LED_BLOCK_ROWS)

// Block size in pixels
`define LED_BLOCK_W 4
`define LED_BLOCK_H 2
`define LED_BLOCK_PIXELS (`LED_BLOCK_W * `LED_BLOCK_H)

// Panel size in pixels
`define LED_PANEL_W (`LED_BLOCK_COLS * `LED_BLOCK_W)
`define LED_PANEL_H (`LED_BLOCK_ROWS * `LED_BLOCK_H)

// Colour depth per channel, equal to the number of bit planes
`define LED_COLOR_BITS 4
`define LED_NUM_CHANNELS 3
`define LED_PIXEL_BITS (`LED_NUM_CHANNELS * `LED_COLOR_BITS)

`endif
